// File: files.f
hw/mem_pkg.sv
hw/request_unit.sv
hw/wb_master.sv
hw/wb_sram.sv
hw/mem_subsys_top.sv
dv/mem_subsys_checker.sv
dv/tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - hw/mem_pkg.sv
  - hw/request_unit.sv
  - hw/wb_master.sv
  - hw/wb_sram.sv
  - hw/mem_subsys_top.sv
  - target: test
    files:
      - dv/mem_subsys_checker.sv
      - dv/tb_mem_subsys.sv

// File: dv/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam word_t       addr_offset = 32'h3300_0000;
    localparam word_t       sram_base   = 32'h3300_0000;
    localparam int unsigned sram_words  = 64;
    localparam int unsigned wait_states = 3;
    localparam int unsigned n_mix       = 96;
    localparam int unsigned n_fetch     = 6;
    // fill pass is two ops per word, each fetch step waits for three fetches
    localparam int unsigned n_ops       = 2 * sram_words + n_mix + 3 * n_fetch + 16;
    localparam int unsigned cycle_limit = n_ops * (wait_states + 8) * 2;
    localparam int unsigned rand_seed   = 32'ha905_d8a2;

    logic  clk;
    logic  rst;
    logic  en;
    logic  memread;
    logic  memwrite;
    word_t data_addr;
    word_t instr_addr;
    word_t wdata;
    word_t instr;
    word_t rdata;
    logic  i_hit;
    logic  d_hit;

    logic  exp_load;  // current data op is a load
    word_t exp_rdata;
    logic  exp_rdata_known;
    word_t exp_instr;
    logic  exp_instr_known;
    int    test_id;
    int    order_errors;
    int    data_errors;
    int    instr_errors;
    int    hold_errors;
    logic  timed_out;

    word_t shadow [sram_words];
    bit    shadow_valid [sram_words];

    mem_subsys_top #(
        .ADDR_OFFSET (addr_offset),
        .SRAM_BASE   (sram_base),
        .SRAM_WORDS  (sram_words),
        .WAIT_STATES (wait_states)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .en_i         (en),
        .memread_i    (memread),
        .memwrite_i   (memwrite),
        .data_addr_i  (data_addr),
        .instr_addr_i (instr_addr),
        .wdata_i      (wdata),
        .instr_o      (instr),
        .rdata_o      (rdata),
        .i_hit_o      (i_hit),
        .d_hit_o      (d_hit)
    );

    mem_subsys_checker #(
        .CYCLE_LIMIT (cycle_limit)
    ) i_checker (
        .clk               (clk),
        .rst               (rst),
        .en_i              (en),
        .i_hit_i           (i_hit),
        .d_hit_i           (d_hit),
        .instr_i           (instr),
        .rdata_i           (rdata),
        .exp_load_i        (exp_load),
        .exp_rdata_i       (exp_rdata),
        .exp_rdata_known_i (exp_rdata_known),
        .exp_instr_i       (exp_instr),
        .exp_instr_known_i (exp_instr_known),
        .test_id_i         (test_id),
        .ru_state_i        (i_dut.i_request_unit.state),
        .data_errors_o     (data_errors),
        .instr_errors_o    (instr_errors),
        .hold_errors_o     (hold_errors),
        .timed_out_o       (timed_out)
    );

    always #20 clk = ~clk;

    // expected word at a cpu address, known is low for never written words
    function automatic word_t ref_word(input word_t cpu_addr, output logic known);
        word_t offset;
        offset = cpu_addr + addr_offset - sram_base;
        known  = 1'b1;
        if (offset >= (word_t'(sram_words) << 2)) begin
            return '0;  // outside the window
        end
        known = shadow_valid[offset >> 2];
        return shadow[offset >> 2];
    endfunction

    task automatic shadow_store(input word_t cpu_addr, input word_t data);
        word_t offset;
        offset = cpu_addr + addr_offset - sram_base;
        if (offset < (word_t'(sram_words) << 2)) begin
            shadow[offset >> 2]       = data;
            shadow_valid[offset >> 2] = 1'b1;
        end
    endtask

    function automatic word_t rand_addr();
        return word_t'($urandom % sram_words) << 2;
    endfunction

    task automatic refresh_instr_exp();
        exp_instr = ref_word(instr_addr, exp_instr_known);
    endtask

    // sample at negedge, resume 2 ns after the following rising edge
    task automatic wait_hit(input logic data);
        do @(negedge clk); while (data ? !d_hit : !i_hit);
        @(posedge clk);
        #2;
    endtask

    task automatic data_op(input logic write, input word_t addr, input word_t data);
        data_addr = addr;
        wdata     = data;
        memwrite  = write;
        memread   = !write;
        exp_load  = !write;
        exp_rdata = ref_word(addr, exp_rdata_known);
        wait_hit(1'b1);
        memwrite = 1'b0;
        memread  = 1'b0;
        exp_load = 1'b0;
        if (write) begin
            shadow_store(addr, data);
            refresh_instr_exp();
        end
    endtask

    task automatic finish_run();
        $display("errors: data %0d, instr %0d, hold %0d, order %0d",
                 data_errors, instr_errors, hold_errors, order_errors);
        if (data_errors + instr_errors + hold_errors + order_errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        wait (timed_out);
        finish_run();
    end

    initial begin
        word_t a;
        word_t d;
        word_t oow;
        void'($urandom(rand_seed));
        clk          = 1'b0;
        rst          = 1'b1;
        en           = 1'b0;
        memread      = 1'b0;
        memwrite     = 1'b0;
        data_addr    = '0;
        instr_addr   = '0;
        wdata        = '0;
        exp_load     = 1'b0;
        exp_rdata    = '0;
        test_id      = 0;
        order_errors = 0;
        refresh_instr_exp();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        en  = 1'b1;

        test_id = 1;
        for (int i = 0; i < sram_words; i++) begin
            a = word_t'(i) << 2;
            data_op(1'b1, a, $urandom);
            data_op(1'b0, a, '0);
        end

        test_id = 2;
        repeat (n_mix) begin
            data_op(1'($urandom), rand_addr(), $urandom);
        end

        test_id = 3;
        repeat (n_fetch) begin
            wait_hit(1'b0);  // change address right after a fetch ends
            instr_addr = rand_addr();
            refresh_instr_exp();
            wait_hit(1'b0);
            wait_hit(1'b0);
        end

        test_id = 4;
        wait_hit(1'b0);
        a         = rand_addr();
        d         = $urandom;
        data_addr = a;
        wdata     = d;
        memwrite  = 1'b1;
        memread   = 1'b1;  // store, load and fetch all pending
        do @(negedge clk); while (!d_hit && !i_hit);
        if (!d_hit) begin
            $display("priority: a fetch finished before the pending store");
            order_errors++;
            do @(negedge clk); while (!d_hit);
        end
        @(posedge clk);
        #2;
        memwrite = 1'b0;
        shadow_store(a, d);
        refresh_instr_exp();
        exp_load  = 1'b1;
        exp_rdata = ref_word(a, exp_rdata_known);
        wait_hit(1'b1);
        memread  = 1'b0;
        exp_load = 1'b0;

        test_id = 5;
        oow = (word_t'(sram_words) << 2) + rand_addr();
        data_op(1'b1, oow, $urandom);
        data_op(1'b0, oow, '0);
        data_op(1'b0, oow - (word_t'(sram_words) << 2), '0);  // aliased word untouched

        test_id   = 6;
        a         = rand_addr();
        data_addr = a;
        memread   = 1'b1;
        exp_load  = 1'b1;
        exp_rdata = ref_word(a, exp_rdata_known);
        repeat (3) @(posedge clk);
        #2;
        en = 1'b0;
        repeat (12) @(posedge clk);
        #2;
        en = 1'b1;
        wait_hit(1'b1);
        memread  = 1'b0;
        exp_load = 1'b0;

        finish_run();
    end

endmodule

`default_nettype wire

// File: dv/mem_subsys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_checker import mem_pkg::*; #(
    parameter int unsigned CYCLE_LIMIT = 1000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       en_i,
    input  logic       i_hit_i,
    input  logic       d_hit_i,
    input  word_t      instr_i,
    input  word_t      rdata_i,
    input  logic       exp_load_i,
    input  word_t      exp_rdata_i,
    input  logic       exp_rdata_known_i,
    input  word_t      exp_instr_i,
    input  logic       exp_instr_known_i,
    input  int         test_id_i,
    input  req_state_t ru_state_i,
    output int         data_errors_o,
    output int         instr_errors_o,
    output int         hold_errors_o,
    output logic       timed_out_o
);

    int unsigned cycles;
    logic        en_q;  // en_i one cycle back, it gates this cycle's outputs
    word_t       instr_q;
    word_t       rdata_q;

    function automatic string test_name(input int id);
        case (id)
            1: return "store_load";
            2: return "random_mix";
            3: return "fetch";
            4: return "priority";
            5: return "out_of_window";
            6: return "hold";
            default: return "reset";
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycles         <= 0;
            en_q           <= 1'b0;
            instr_q        <= '0;
            rdata_q        <= '0;
            data_errors_o  <= 0;
            instr_errors_o <= 0;
            hold_errors_o  <= 0;
            timed_out_o    <= 1'b0;
        end else begin
            cycles  <= cycles + 1;
            en_q    <= en_i;
            instr_q <= instr_i;
            rdata_q <= rdata_i;
            if (d_hit_i && exp_load_i && exp_rdata_known_i && rdata_i !== exp_rdata_i) begin
                $display("[ERROR] %s: rdata expected %08h, actual %08h",
                         test_name(test_id_i), exp_rdata_i, rdata_i);
                data_errors_o <= data_errors_o + 1;
            end
            if (i_hit_i && exp_instr_known_i && instr_i !== exp_instr_i) begin
                $display("[ERROR] %s: instr expected %08h, actual %08h",
                         test_name(test_id_i), exp_instr_i, instr_i);
                instr_errors_o <= instr_errors_o + 1;
            end
            if (!en_q && (d_hit_i || i_hit_i)) begin
                $display("%s: hit pulse while en_i was low", test_name(test_id_i));
                hold_errors_o <= hold_errors_o + 1;
            end else if (!en_q && (instr_i !== instr_q || rdata_i !== rdata_q)) begin
                $display("%s: read outputs changed while en_i was low", test_name(test_id_i));
                hold_errors_o <= hold_errors_o + 1;
            end
            if (cycles == CYCLE_LIMIT) begin
                $display("run timed out after %0d cycles in %s, request unit in state %s",
                         cycles, test_name(test_id_i), ru_state_i.name());
                timed_out_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; #(
    parameter word_t       ADDR_OFFSET = mem_base,
    parameter word_t       SRAM_BASE   = mem_base,
    parameter int unsigned SRAM_WORDS  = 256,
    parameter int unsigned WAIT_STATES = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  en_i,
    input  logic  memread_i,
    input  logic  memwrite_i,
    input  word_t data_addr_i,
    input  word_t instr_addr_i,
    input  word_t wdata_i,
    output word_t instr_o,
    output word_t rdata_o,
    output logic  i_hit_o,
    output logic  d_hit_o
);

    // request unit <-> master
    logic  read_req;
    logic  write_req;
    word_t req_adr;
    word_t req_wdat;
    logic  busy;
    word_t rdat;

    // wishbone classic
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    word_t wb_adr;
    word_t wb_dat_m2s;
    logic  wb_ack;
    word_t wb_dat_s2m;

    request_unit #(
        .ADDR_OFFSET(ADDR_OFFSET)
    ) i_request_unit (
        .clk          (clk),
        .rst          (rst),
        .en_i         (en_i),
        .memread_i    (memread_i),
        .memwrite_i   (memwrite_i),
        .data_addr_i  (data_addr_i),
        .instr_addr_i (instr_addr_i),
        .wdata_i      (wdata_i),
        .busy_i       (busy),
        .rdat_i       (rdat),
        .read_req_o   (read_req),
        .write_req_o  (write_req),
        .req_adr_o    (req_adr),
        .req_wdat_o   (req_wdat),
        .instr_o      (instr_o),
        .rdata_o      (rdata_o),
        .i_hit_o      (i_hit_o),
        .d_hit_o      (d_hit_o)
    );

    wb_master i_wb_master (
        .clk         (clk),
        .rst         (rst),
        .read_req_i  (read_req),
        .write_req_i (write_req),
        .req_adr_i   (req_adr),
        .req_wdat_i  (req_wdat),
        .busy_o      (busy),
        .rdat_o      (rdat),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_dat_o    (wb_dat_m2s),
        .wb_ack_i    (wb_ack),
        .wb_dat_i    (wb_dat_s2m)
    );

    wb_sram #(
        .SRAM_BASE   (SRAM_BASE),
        .SRAM_WORDS  (SRAM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) i_wb_sram (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_m2s),
        .wb_ack_o (wb_ack),
        .wb_dat_o (wb_dat_s2m)
    );

endmodule

`default_nettype wire

// File: hw/wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sram import mem_pkg::*; #(
    parameter word_t       SRAM_BASE   = mem_base,
    parameter int unsigned SRAM_WORDS  = 256,
    parameter int unsigned WAIT_STATES = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  logic  wb_we_i,
    input  word_t wb_adr_i,
    input  word_t wb_dat_i,
    output logic  wb_ack_o,
    output word_t wb_dat_o
);

    localparam int unsigned idx_w     = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;
    localparam int unsigned cnt_w     = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam word_t       win_bytes = word_t'(SRAM_WORDS) << addr_lsb;

    word_t            offset;
    logic             in_win;
    logic [idx_w-1:0] idx;
    logic [cnt_w-1:0] wait_cnt;
    logic             active;
    logic             access;
    word_t            mem [SRAM_WORDS];

    assign offset = wb_adr_i - SRAM_BASE;  // wraps below base, so one compare
    assign in_win = offset < win_bytes;
    assign idx    = offset[addr_lsb +: idx_w];
    assign active = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign access = active && (wait_cnt == cnt_w'(WAIT_STATES));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;  // single cycle ack
            if (active && !access) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    // outside the window writes vanish and reads give zero
    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_we_i && in_win) begin
                mem[idx] <= wb_dat_i;
            end
            wb_dat_o <= (!wb_we_i && in_win) ? mem[idx] : '0;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("ack outside a bus cycle");

endmodule

`default_nettype wire

// File: hw/wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_master import mem_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  read_req_i,
    input  logic  write_req_i,
    input  word_t req_adr_i,
    input  word_t req_wdat_i,
    output logic  busy_o,
    output word_t rdat_o,
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output word_t wb_adr_o,
    output word_t wb_dat_o,
    input  logic  wb_ack_i,
    input  word_t wb_dat_i
);

    logic start;
    logic done;

    // one request at a time, requester waits for busy to fall
    assign start = (read_req_i || write_req_i) && !busy_o;
    assign done  = wb_cyc_o && wb_ack_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_o   <= 1'b0;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end else if (start) begin
            busy_o   <= 1'b1;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
            wb_we_o  <= write_req_i;
        end else if (done) begin
            // classic cycle closes the cycle after ack
            busy_o   <= 1'b0;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
        end
    end

    // address and write data stay put for the whole bus cycle
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr_o <= req_adr_i;
            wb_dat_o <= req_wdat_i;
        end
    end

    // read word, seen by the requester once busy is low
    always_ff @(posedge clk) begin
        if (done && !wb_we_o) begin
            rdat_o <= wb_dat_i;
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
        (read_req_i || write_req_i) |-> !busy_o)
        else $error("request while a transfer is in flight");

endmodule

`default_nettype wire

// File: hw/request_unit.sv
`timescale 1ns/1ps
`default_nettype none

module request_unit import mem_pkg::*; #(
    parameter word_t ADDR_OFFSET = mem_base
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  en_i,
    input  logic  memread_i,
    input  logic  memwrite_i,
    input  word_t data_addr_i,
    input  word_t instr_addr_i,
    input  word_t wdata_i,
    input  logic  busy_i,
    input  word_t rdat_i,
    output logic  read_req_o,
    output logic  write_req_o,
    output word_t req_adr_o,
    output word_t req_wdat_o,
    output word_t instr_o,
    output word_t rdata_o,
    output logic  i_hit_o,
    output logic  d_hit_o
);

    req_state_t state;
    req_state_t next_state;
    logic       next_read_req;
    logic       next_write_req;
    logic       next_i_hit;
    logic       next_d_hit;
    logic       busy_seen;  // master went busy for the current access
    logic       busy_fell;
    word_t      next_adr;
    word_t      next_wdat;
    word_t      next_instr;
    word_t      next_rdata;

    // high to low edge of busy, also when it fell while en_i was low
    assign busy_fell = busy_seen && !busy_i;

    always_comb begin
        next_state     = state;
        next_read_req  = 1'b0;
        next_write_req = 1'b0;
        next_i_hit     = 1'b0;
        next_d_hit     = 1'b0;
        next_adr       = req_adr_o;
        next_wdat      = req_wdat_o;
        next_instr     = instr_o;
        next_rdata     = rdata_o;
        unique case (state)
            idle: begin
                // write first, then read, then fetch
                if (memwrite_i && !d_hit_o) begin
                    next_state     = wait_write;
                    next_write_req = 1'b1;
                    next_adr       = data_addr_i + ADDR_OFFSET;
                    next_wdat      = wdata_i;
                end else if (memread_i && !d_hit_o) begin
                    next_state    = wait_read;
                    next_read_req = 1'b1;
                    next_adr      = data_addr_i + ADDR_OFFSET;
                end else if (!i_hit_o) begin
                    next_state    = wait_instr;
                    next_read_req = 1'b1;
                    next_adr      = instr_addr_i + ADDR_OFFSET;
                end
            end
            wait_read:  next_state = mem_read;
            wait_write: next_state = mem_write;
            wait_instr: next_state = instr_read;
            mem_read: begin
                if (busy_fell) begin
                    next_state = idle;
                    next_d_hit = 1'b1;
                    next_rdata = rdat_i;  // valid right after busy drops
                end
            end
            mem_write: begin
                if (busy_fell) begin
                    next_state = idle;
                    next_d_hit = 1'b1;
                end
            end
            instr_read: begin
                if (busy_fell) begin
                    next_state = idle;
                    next_i_hit = 1'b1;
                    next_instr = rdat_i;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= idle;
            read_req_o  <= 1'b0;
            write_req_o <= 1'b0;
            i_hit_o     <= 1'b0;
            d_hit_o     <= 1'b0;
            instr_o     <= '0;
            rdata_o     <= '0;
        end else begin
            // pulses never stretch, even when en_i drops
            read_req_o  <= en_i && next_read_req;
            write_req_o <= en_i && next_write_req;
            i_hit_o     <= en_i && next_i_hit;
            d_hit_o     <= en_i && next_d_hit;
            if (en_i) begin
                state   <= next_state;
                instr_o <= next_instr;
                rdata_o <= next_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            req_adr_o  <= next_adr;
            req_wdat_o <= next_wdat;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_seen <= 1'b0;
        end else if (busy_i) begin
            busy_seen <= 1'b1;
        end else if (en_i && (next_i_hit || next_d_hit)) begin
            busy_seen <= 1'b0;  // access taken
        end
    end

    a_req_excl: assert property (@(posedge clk) disable iff (rst)
        !(read_req_o && write_req_o))
        else $error("read and write request together");

    a_req_pulse: assert property (@(posedge clk) disable iff (rst)
        (read_req_o || write_req_o) |=> !(read_req_o || write_req_o))
        else $error("request longer than one cycle");

    a_d_hit_src: assert property (@(posedge clk) disable iff (rst)
        d_hit_o |-> $past(state inside {mem_read, mem_write}))
        else $error("d_hit without a data access");

    a_i_hit_src: assert property (@(posedge clk) disable iff (rst)
        i_hit_o |-> $past(state == instr_read))
        else $error("i_hit without a fetch");

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // width of every data and address word on the path
    localparam int unsigned xlen = 32;

    // byte offset bits inside a word, word index starts above them
    localparam int unsigned addr_lsb = 2;

    typedef logic [xlen-1:0] word_t;

    // default placement of the word memory in the bus address map
    localparam word_t mem_base = 32'h3300_0000;

    // request unit states
    // each access goes idle -> wait_* -> mem_* (or instr_read) -> idle
    typedef enum logic [2:0] {
        idle       = 3'd0,
        wait_read  = 3'd1,  // read pulse on the wire
        mem_read   = 3'd2,  // waiting for busy to fall
        wait_write = 3'd3,
        mem_write  = 3'd4,
        wait_instr = 3'd5,
        instr_read = 3'd6
    } req_state_t;

endpackage

`default_nettype wire
